// File: common/id_pkg.sv
`default_nettype none

package id_pkg;

  ////////////////////////////////////////
  // Widths fixed by the ISA
  ////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_BRANCH = 7'b1100011,
    OPCODE_JALR   = 7'b1100111,
    OPCODE_JAL    = 7'b1101111
  } opcode_e;

  // Seventeen operations, one more than four bits can hold
  typedef enum logic [4:0] {
    ALU_NOP, ALU_ADD, ALU_SUB,
    ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;

  // PCINCR is the link offset, constant 4
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_PCINCR} imm_sel_e;

  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fwd_sel_e;
  typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR, JUMP_BRANCH} jump_e;

  // Same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_type_e;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // Decoder output
  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    imm_sel_e  imm_sel;
    logic      use_op_c;      // operand C carries the jump target
    logic      rd_we;
    logic      mem_req;
    logic      mem_we;
    mem_type_e mem_type;
    logic      mem_sign_ext;
    jump_e     jump;
    logic      illegal;
  } ctrl_t;

  // Register write port, also a forwarding source
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } wr_port_t;

  // ID/EX payload
  typedef struct packed {
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;
    logic [XLEN-1:0]       rb_data;   // store data
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  rd_we;
    logic                  mem_req;
    logic                  mem_we;
    mem_type_e             mem_type;
    logic                  mem_sign_ext;
    jump_e                 jump;
    logic                  illegal;
  } id_ex_t;

endpackage

`default_nettype wire

// File: hw/id_ex_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_pipe (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid_i,
  output logic           in_ready_o,
  input  id_pkg::id_ex_t payload_i,
  input  logic           ex_ready_i,
  output logic           ex_valid_o,
  output id_pkg::id_ex_t id_ex_o
);

  // Empty slot or slot leaving this cycle
  assign in_ready_o = ex_ready_i | ~ex_valid_o;

  ////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_valid_o <= 1'b0;
    end
    else if (in_ready_o)
    begin
      // Drops when the held item leaves and nothing follows
      ex_valid_o <= in_valid_i;
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      // Zero is NOP with no writes
      id_ex_o <= '0;
    end
    else if (in_ready_o && in_valid_i)
    begin
      id_ex_o <= payload_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic             clk,
  input  logic             rst_n,

  // From fetch
  input  logic             instr_valid_i,
  output logic             instr_ready_o,
  input  logic [31:0]      instr_i,
  input  logic [31:0]      pc_i,

  // Write and forward ports
  input  id_pkg::wr_port_t wb_i,
  input  id_pkg::wr_port_t alu_fw_i,

  // To execute
  input  logic             ex_ready_i,
  output logic             ex_valid_o,
  output id_pkg::id_ex_t   id_ex_o
);

  import id_pkg::*;

  ctrl_t           ctrl;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  id_ex_t          payload;

  ////////////////////////////////////////
  // Decode and register read
  ////////////////////////////////////////

  riscv_decoder u_decoder (
    .instr_i (instr_i),
    .ctrl_o  (ctrl)
  );

  // rs1 and rs2 fields
  register_file u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (instr_i[19:15]),
    .raddr_b_i (instr_i[24:20]),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wb_i      (wb_i),
    .alu_fw_i  (alu_fw_i)
  );

  ////////////////////////////////////////
  // Operands and ID/EX register
  ////////////////////////////////////////

  operand_mux u_operand_mux (
    .instr_i   (instr_i),
    .pc_i      (pc_i),
    .ctrl_i    (ctrl),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .wb_i      (wb_i),
    .alu_fw_i  (alu_fw_i),
    .payload_o (payload)
  );

  id_ex_pipe u_id_ex_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (instr_valid_i),
    .in_ready_o (instr_ready_o),
    .payload_i  (payload),
    .ex_ready_i (ex_ready_i),
    .ex_valid_o (ex_valid_o),
    .id_ex_o    (id_ex_o)
  );

endmodule

`default_nettype wire

// File: hw/operand_mux.sv
`timescale 1ns/1ps
`default_nettype none

module operand_mux (
  input  logic [31:0]      instr_i,
  input  logic [31:0]      pc_i,
  input  id_pkg::ctrl_t    ctrl_i,
  input  logic [31:0]      rdata_a_i,
  input  logic [31:0]      rdata_b_i,
  input  id_pkg::wr_port_t wb_i,
  input  id_pkg::wr_port_t alu_fw_i,
  output id_pkg::id_ex_t   payload_o
);

  import id_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_mux;

  fwd_sel_e        fwd_a_sel;
  fwd_sel_e        fwd_b_sel;
  logic [XLEN-1:0] fwd_a;
  logic [XLEN-1:0] fwd_b;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] jump_target;

  // Newest producer first, x0 never forwarded
  function automatic fwd_sel_e fwd_select(input logic [REG_ADDR_W-1:0] src,
                                          input wr_port_t alu, input wr_port_t wb);
    fwd_sel_e sel;
    sel = SEL_REGFILE;
    if (src != '0)
    begin
      if (alu.we && (alu.addr == src))
        sel = SEL_FW_EX;
      else if (wb.we && (wb.addr == src))
        sel = SEL_FW_WB;
    end
    return sel;
  endfunction

  function automatic logic [XLEN-1:0] fwd_data(input fwd_sel_e sel, input logic [XLEN-1:0] rf,
                                               input wr_port_t alu, input wr_port_t wb);
    logic [XLEN-1:0] val;
    case (sel)
      SEL_FW_EX: val = alu.data;
      SEL_FW_WB: val = wb.data;
      default:   val = rf;
    endcase
    return val;
  endfunction

  ////////////////////////////////////////
  // Immediates, all sign extended
  ////////////////////////////////////////

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb
  begin
    case (ctrl_i.imm_sel)
      IMM_I:      imm_mux = imm_i;
      IMM_S:      imm_mux = imm_s;
      IMM_B:      imm_mux = imm_b;
      IMM_U:      imm_mux = imm_u;
      IMM_J:      imm_mux = imm_j;
      IMM_PCINCR: imm_mux = XLEN'(4);
      default:    imm_mux = '0;
    endcase
  end

  ////////////////////////////////////////
  // Forwarding and operands
  ////////////////////////////////////////

  assign fwd_a_sel = fwd_select(instr_i[19:15], alu_fw_i, wb_i);
  assign fwd_b_sel = fwd_select(instr_i[24:20], alu_fw_i, wb_i);
  assign fwd_a     = fwd_data(fwd_a_sel, rdata_a_i, alu_fw_i, wb_i);
  assign fwd_b     = fwd_data(fwd_b_sel, rdata_b_i, alu_fw_i, wb_i);

  always_comb
  begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   op_a = pc_i;
      OP_A_ZERO: op_a = '0;
      default:   op_a = fwd_a;
    endcase
  end

  assign op_b = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_mux : fwd_b;

  // Target for operand C
  always_comb
  begin
    case (ctrl_i.jump)
      JUMP_JAL:    jump_target = pc_i + imm_j;
      JUMP_JALR:   jump_target = fwd_a + imm_i;
      JUMP_BRANCH: jump_target = pc_i + imm_b;
      default:     jump_target = '0;
    endcase
  end

  always_comb
  begin
    payload_o.alu_op       = ctrl_i.alu_op;
    payload_o.operand_a    = op_a;
    payload_o.operand_b    = op_b;
    payload_o.operand_c    = ctrl_i.use_op_c ? jump_target : '0;
    payload_o.rb_data      = fwd_b;
    payload_o.rd_addr      = instr_i[11:7];
    payload_o.rd_we        = ctrl_i.rd_we;
    payload_o.mem_req      = ctrl_i.mem_req;
    payload_o.mem_we       = ctrl_i.mem_we;
    payload_o.mem_type     = ctrl_i.mem_type;
    payload_o.mem_sign_ext = ctrl_i.mem_sign_ext;
    payload_o.jump         = ctrl_i.jump;
    payload_o.illegal      = ctrl_i.illegal;
  end

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [4:0]       raddr_a_i,
  input  logic [4:0]       raddr_b_i,
  output logic [31:0]      rdata_a_o,
  output logic [31:0]      rdata_b_o,
  input  id_pkg::wr_port_t wb_i,
  input  id_pkg::wr_port_t alu_fw_i
);

  import id_pkg::*;

  // x1..x31 only, x0 has no storage
  logic [NUM_REGS-1:1][XLEN-1:0] regs_q;

  // Address match over the stored registers, x0 falls through as zero
  function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr,
                                               input logic [NUM_REGS-1:1][XLEN-1:0] regs);
    logic [XLEN-1:0] val;
    val = '0;
    for (int i = 1; i < NUM_REGS; i++)
    begin
      if (addr == REG_ADDR_W'(i))
        val = regs[i];
    end
    return val;
  endfunction

  assign rdata_a_o = read_reg(raddr_a_i, regs_q);
  assign rdata_b_o = read_reg(raddr_b_i, regs_q);

  ////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      regs_q <= '0;
    end
    else
    begin
      for (int i = 1; i < NUM_REGS; i++)
      begin
        // ALU port wins a collision
        if (alu_fw_i.we && (alu_fw_i.addr == REG_ADDR_W'(i)))
          regs_q[i] <= alu_fw_i.data;
        else if (wb_i.we && (wb_i.addr == REG_ADDR_W'(i)))
          regs_q[i] <= wb_i.data;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/riscv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_decoder (
  input  logic [31:0]   instr_i,
  output id_pkg::ctrl_t ctrl_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;      // instr[30], picks SUB and SRA
  logic       bad;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign alt    = instr_i[30];

  // Shared by OP and OP-IMM
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_ok,
                                       input logic alt_bit);
    alu_op_e op;
    case (f3)
      3'b000:  op = (sub_ok && alt_bit) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb
  begin
    // All zero is a NOP with nothing written
    ctrl_o = '0;
    bad    = 1'b0;

    case (opcode)
      OPCODE_OP:
      begin
        ctrl_o.alu_op = arith_op(funct3, 1'b1, alt);
        ctrl_o.rd_we  = 1'b1;
      end

      OPCODE_OP_IMM:
      begin
        // No SUBI, instr[30] is immediate there
        ctrl_o.alu_op   = arith_op(funct3, 1'b0, alt);
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_I;
        ctrl_o.rd_we    = 1'b1;
      end

      OPCODE_LUI, OPCODE_AUIPC:
      begin
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op_a_sel = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
        ctrl_o.rd_we    = 1'b1;
      end

      OPCODE_JAL, OPCODE_JALR:
      begin
        // Link value PC+4, target goes on operand C
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_PCINCR;
        ctrl_o.use_op_c = 1'b1;
        ctrl_o.rd_we    = 1'b1;
        ctrl_o.jump     = (opcode == OPCODE_JAL) ? JUMP_JAL : JUMP_JALR;
        if ((opcode == OPCODE_JALR) && (funct3 != 3'b000))
          bad = 1'b1;
      end

      OPCODE_BRANCH:
      begin
        ctrl_o.imm_sel  = IMM_B;
        ctrl_o.use_op_c = 1'b1;
        ctrl_o.jump     = JUMP_BRANCH;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: bad = 1'b1;
        endcase
      end

      OPCODE_LOAD:
      begin
        // Address rs1 + I, LBU/LHU zero extend
        ctrl_o.alu_op       = ALU_ADD;
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.imm_sel      = IMM_I;
        ctrl_o.rd_we        = 1'b1;
        ctrl_o.mem_req      = 1'b1;
        ctrl_o.mem_type     = mem_type_e'(funct3[1:0]);
        ctrl_o.mem_sign_ext = ~funct3[2];
        if ((funct3[1:0] == 2'b11) || (funct3 == 3'b110))
          bad = 1'b1;
      end

      OPCODE_STORE:
      begin
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_S;
        ctrl_o.mem_req  = 1'b1;
        ctrl_o.mem_we   = 1'b1;
        ctrl_o.mem_type = mem_type_e'(funct3[1:0]);
        if ((funct3[2] == 1'b1) || (funct3[1:0] == 2'b11))
          bad = 1'b1;
      end

      default: bad = 1'b1;
    endcase

    // Illegal becomes a bubble
    if (bad)
    begin
      ctrl_o         = '0;
      ctrl_o.illegal = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the ID stage testbench with Verilator and run it
verilator --binary --timing --top-module tb_id_stage -f sim.f \
  && ./obj_dir/Vtb_id_stage | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: sim.f
common/id_pkg.sv
hw/riscv_decoder.sv
hw/register_file.sv
hw/operand_mux.sv
hw/id_ex_pipe.sv
hw/id_stage.sv
tb/tb_id_stage.sv

// File: tb/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  import id_pkg::*;

  localparam int NUM_RANDOM  = 300;
  // Directed reads, register fill, stall burst, random traffic
  localparam int NUM_TESTS   = 32 + 32 + 8 + NUM_RANDOM;
  localparam int WATCHDOG_NS = NUM_TESTS * 20 * 4;
  localparam wr_port_t IDLE_PORT = '0;

  logic        clk;
  logic        rst_n;
  logic        instr_valid_i;
  logic        instr_ready_o;
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  wr_port_t    wb_i;
  wr_port_t    alu_fw_i;
  logic        ex_ready_i;
  logic        ex_valid_o;
  id_ex_t      id_ex_o;

  logic [31:0] lfsr_q = 32'd29;
  // Shadow of the register file, x0 entry never written
  logic [31:0] shadow [NUM_REGS] = '{default: '0};
  id_ex_t      exp_q [$];
  int          accepted = 0;

  id_stage DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .wb_i          (wb_i),
    .alu_fw_i      (alu_fw_i),
    .ex_ready_i    (ex_ready_i),
    .ex_valid_o    (ex_valid_o),
    .id_ex_o       (id_ex_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = next_lfsr(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] sel;
    logic [31:0] fields;
    logic [6:0]  opcode;
    sel    = take_bits(4);
    fields = take_bits(25);
    case (sel % 10)
      0:       opcode = 7'b0110011;  // OP
      1:       opcode = 7'b0010011;  // OP-IMM
      2:       opcode = 7'b0110111;  // LUI
      3:       opcode = 7'b0010111;  // AUIPC
      4:       opcode = 7'b1101111;  // JAL
      5:       opcode = 7'b1100111;  // JALR
      6:       opcode = 7'b1100011;  // BRANCH
      7:       opcode = 7'b0000011;  // LOAD
      8:       opcode = 7'b0100011;  // STORE
      default: opcode = 7'b1110011;  // SYSTEM, unsupported
    endcase
    return {fields[24:0], opcode};
  endfunction

  // Address often hits rs1 or rs2 so forwarding gets exercised
  function automatic wr_port_t random_port(input logic [31:0] instr);
    wr_port_t    p;
    logic [31:0] bits;
    bits = take_bits(8);
    p.we = bits[7];
    case (bits[6:5])
      2'b00:   p.addr = instr[19:15];
      2'b01:   p.addr = instr[24:20];
      default: p.addr = bits[4:0];
    endcase
    p.data = take_bits(32);
    return p;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // ALU port first, then writeback, then the shadow
  function automatic logic [31:0] source_value(input logic [4:0] addr, input wr_port_t wb,
                                               input wr_port_t alu);
    if (addr == 5'd0)
      return '0;
    if (alu.we && (alu.addr == addr))
      return alu.data;
    if (wb.we && (wb.addr == addr))
      return wb.data;
    return shadow[addr];
  endfunction

  function automatic void update_shadow(input wr_port_t wb, input wr_port_t alu);
    if (alu.we && (alu.addr != 5'd0))
      shadow[alu.addr] = alu.data;
    if (wb.we && (wb.addr != 5'd0) && !(alu.we && (alu.addr == wb.addr)))
      shadow[wb.addr] = wb.data;
  endfunction

  function automatic id_ex_t expected_payload(input logic [31:0] instr, input logic [31:0] pc,
                                              input wr_port_t wb, input wr_port_t alu);
    id_ex_t      e;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic        ok;
    f3      = instr[14:12];
    rs1_val = source_value(instr[19:15], wb, alu);
    rs2_val = source_value(instr[24:20], wb, alu);
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u   = {instr[31:12], 12'h000};
    imm_j   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    e           = '0;
    e.operand_a = rs1_val;
    e.operand_b = rs2_val;
    e.rb_data   = rs2_val;
    e.rd_addr   = instr[11:7];
    e.alu_op    = ALU_ADD;
    ok          = 1'b1;
    case (instr[6:0])
      7'b0110011, 7'b0010011:
      begin
        // SUB only in OP, SRA in both
        case (f3)
          3'b000:  e.alu_op = (instr[5] && instr[30]) ? ALU_SUB : ALU_ADD;
          3'b001:  e.alu_op = ALU_SLL;
          3'b010:  e.alu_op = ALU_SLT;
          3'b011:  e.alu_op = ALU_SLTU;
          3'b100:  e.alu_op = ALU_XOR;
          3'b101:  e.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
          3'b110:  e.alu_op = ALU_OR;
          default: e.alu_op = ALU_AND;
        endcase
        if (!instr[5])
          e.operand_b = imm_i;
        e.rd_we = 1'b1;
      end
      7'b0110111, 7'b0010111:
      begin
        e.operand_a = instr[5] ? 32'd0 : pc;
        e.operand_b = imm_u;
        e.rd_we     = 1'b1;
      end
      7'b1101111, 7'b1100111:
      begin
        // Link value in A+B, target in C
        ok          = instr[3] || (f3 == 3'b000);
        e.operand_a = pc;
        e.operand_b = 32'd4;
        e.operand_c = instr[3] ? (pc + imm_j) : (rs1_val + imm_i);
        e.rd_we     = 1'b1;
        e.jump      = instr[3] ? JUMP_JAL : JUMP_JALR;
      end
      7'b1100011:
      begin
        case (f3)
          3'b000:  e.alu_op = ALU_EQ;
          3'b001:  e.alu_op = ALU_NE;
          3'b100:  e.alu_op = ALU_LT;
          3'b101:  e.alu_op = ALU_GE;
          3'b110:  e.alu_op = ALU_LTU;
          3'b111:  e.alu_op = ALU_GEU;
          default: ok = 1'b0;
        endcase
        e.operand_c = pc + imm_b;
        e.jump      = JUMP_BRANCH;
      end
      7'b0000011:
      begin
        ok             = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
        e.operand_b    = imm_i;
        e.rd_we        = 1'b1;
        e.mem_req      = 1'b1;
        e.mem_type     = mem_type_e'(f3[1:0]);
        e.mem_sign_ext = !f3[2];
      end
      7'b0100011:
      begin
        ok          = (f3 <= 3'b010);
        e.operand_b = imm_s;
        e.mem_req   = 1'b1;
        e.mem_we    = 1'b1;
        e.mem_type  = mem_type_e'(f3[1:0]);
      end
      default: ok = 1'b0;
    endcase
    // Bubble keeps register operands only
    if (!ok)
    begin
      e.alu_op       = ALU_NOP;
      e.operand_a    = rs1_val;
      e.operand_b    = rs2_val;
      e.operand_c    = '0;
      e.rd_we        = 1'b0;
      e.mem_req      = 1'b0;
      e.mem_we       = 1'b0;
      e.mem_type     = MEM_BYTE;
      e.mem_sign_ext = 1'b0;
      e.jump         = JUMP_NONE;
      e.illegal      = 1'b1;
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_payload(input string what, input id_ex_t got, input id_ex_t want);
    if (got !== want)
      fail_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, want));
  endtask

  task automatic compare_bit(input string what, input logic got, input logic want);
    if (got !== want)
      fail_run($sformatf("ERR %0t: %s got %b expected %b", $time, what, got, want));
  endtask

  // Inputs are stable mid-cycle, model follows the coming edge
  always @(negedge clk)
  begin
    logic ready_exp;
    // Slot empty in the model, or its item leaves at the coming edge
    ready_exp = ex_ready_i || (exp_q.size() == 0);
    if (rst_n)
    begin
      compare_bit("instr_ready_o", instr_ready_o, ready_exp);
      compare_bit("ex_valid_o", ex_valid_o, exp_q.size() != 0);
      if (exp_q.size() != 0)
      begin
        // Held payload checked every cycle, popped on transfer
        compare_payload("id_ex_o", id_ex_o, exp_q[0]);
        if (ex_ready_i)
          void'(exp_q.pop_front());
      end
      if (instr_valid_i && ready_exp)
      begin
        exp_q.push_back(expected_payload(instr_i, pc_i, wb_i, alu_fw_i));
        accepted++;
      end
      update_shadow(wb_i, alu_fw_i);
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic drive_cycle(input logic valid, input logic [31:0] instr, input logic [31:0] pc,
                             input wr_port_t wb, input wr_port_t alu, input logic ready);
    @(posedge clk);
    instr_valid_i <= valid;
    instr_i       <= instr;
    pc_i          <= pc;
    wb_i          <= wb;
    alu_fw_i      <= alu;
    ex_ready_i    <= ready;
  endtask

  initial
  begin
    wr_port_t    wb;
    wr_port_t    alu;
    logic [31:0] instr;
    logic [31:0] bits;
    logic [31:0] pc;
    logic [4:0]  a;
    int          target;
    rst_n         <= 1'b0;
    instr_valid_i <= 1'b0;
    instr_i       <= '0;
    pc_i          <= '0;
    wb_i          <= '0;
    alu_fw_i      <= '0;
    ex_ready_i    <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_bit("ex_valid_o after reset", ex_valid_o, 1'b0);
    compare_payload("id_ex_o after reset", id_ex_o, '0);

    // Empty register file through R-type reads
    for (int r = 0; r < 32; r++)
    begin
      a     = 5'(r);
      instr = {1'b0, a[3], 5'b0, ~a, a, a[2:0], a, 7'b0110011};
      drive_cycle(1'b1, instr, 32'(r * 4), IDLE_PORT, IDLE_PORT, 1'b1);
    end

    // Fill through writeback, x0 write must be dropped
    for (int r = 0; r < 32; r++)
    begin
      bits = take_bits(32);
      wb   = '{we: 1'b1, addr: 5'(r), data: bits};
      drive_cycle(1'b0, '0, '0, wb, IDLE_PORT, 1'b1);
    end

    // Execute stalled, first one held
    for (int c = 0; c < 8; c++)
    begin
      instr = random_instr();
      bits  = take_bits(30);
      drive_cycle(1'b1, instr, {bits[29:0], 2'b00}, IDLE_PORT, IDLE_PORT, 1'b0);
    end

    // Random traffic with both ports live
    target = accepted + NUM_RANDOM;
    while (accepted < target)
    begin
      instr = random_instr();
      wb    = random_port(instr);
      alu   = random_port(instr);
      pc    = take_bits(30);
      bits  = take_bits(4);
      drive_cycle(bits[0] | bits[1], instr, {pc[29:0], 2'b00}, wb, alu, bits[2] | bits[3]);
    end

    // Drain
    drive_cycle(1'b0, '0, '0, IDLE_PORT, IDLE_PORT, 1'b1);
    for (int c = 0; (c < 10) && (exp_q.size() != 0); c++)
      @(posedge clk);
    @(negedge clk);
    if ((exp_q.size() != 0) || ex_valid_o)
      fail_run("Accepted instructions never left the stage during the drain");
    else
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    fail_run("Timeout, the simulation did not finish in the expected time");
  end

endmodule

`default_nettype wire
